// File: ram_writer_cfg_pkg.sv
`default_nettype none

package ram_writer_cfg_pkg;

  // Stream and AXI data widths
  localparam int word_width = 32;               // One stream sample
  localparam int beat_width = 2 * word_width;   // Two samples per AXI beat

  // Address and ID
  localparam int addr_width = 32;               // Byte address
  localparam int id_width   = 6;                // awid and wid

  // Fixed burst shape, INCR with full-width beats
  localparam int axi_size    = 3;               // awsize, log2 of bytes per beat
  localparam int beat_bytes  = 1 << axi_size;   // 8 bytes per beat
  localparam int burst_beats = 16;              // Beats per burst
  localparam int len_width   = 4;               // AXI3 awlen field

  // The awlen value of every burst
  localparam logic [len_width-1:0] burst_len = len_width'(burst_beats - 1);

  localparam int burst_bytes = burst_beats * beat_bytes; // Address step per burst

  // Beat FIFO
  localparam int fifo_depth  = 32;                       // Beats held
  localparam int ptr_width   = $clog2(fifo_depth);       // Read and write pointers
  localparam int count_width = $clog2(fifo_depth + 1);   // Occupancy 0 to fifo_depth

endpackage

`default_nettype wire

// File: ram_writer_axi_pkg.sv
`default_nettype none

package ram_writer_axi_pkg;

  // One 64-bit beat as held in the FIFO
  typedef struct packed {
    logic [ram_writer_cfg_pkg::word_width-1:0] hi; // Later word of the pair
    logic [ram_writer_cfg_pkg::word_width-1:0] lo; // Earlier word of the pair
  } beat_t;

  // Write address request
  typedef struct packed {
    logic [ram_writer_cfg_pkg::id_width-1:0]   id;   // awid
    logic [ram_writer_cfg_pkg::addr_width-1:0] addr; // awaddr, burst start
    logic [ram_writer_cfg_pkg::len_width-1:0]  len;  // awlen
  } aw_t;

  // Write data beat, strobes are all ones and not carried
  typedef struct packed {
    logic [ram_writer_cfg_pkg::id_width-1:0] id;   // wid, same as the burst awid
    beat_t                                   data; // wdata
    logic                                    last; // wlast
  } w_t;

endpackage

`default_nettype wire

// File: word_packer.sv
`timescale 1ns/1ps
`default_nettype none

module word_packer
(
  input  wire                                        aclk,
  input  wire                                        aresetn,
  input  wire  [ram_writer_cfg_pkg::word_width-1:0]  s_tdata,
  input  wire                                        s_tvalid,
  output logic                                       s_tready,
  input  wire                                        full,
  output logic                                       push,
  output ram_writer_axi_pkg::beat_t                  push_beat
);

  logic                                     phase_q; // High while a first word is held
  logic [ram_writer_cfg_pkg::word_width-1:0] first_q; // Earlier word of the pair
  logic                                     accept;

  assign s_tready = ~full;
  assign accept   = s_tvalid & s_tready;  // Stream handshake

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      phase_q <= 1'b0;
      push    <= 1'b0;
    end
    else
    begin
      push <= accept & phase_q;          // Pair complete, one-cycle pulse
      if (accept)
        phase_q <= ~phase_q;
    end
  end

  // First word waits here until its partner arrives
  always_ff @(posedge aclk)
  begin
    if (accept & ~phase_q)
      first_q <= s_tdata;
    if (accept & phase_q)
    begin
      push_beat.hi <= s_tdata;           // Second word in the upper half
      push_beat.lo <= first_q;
    end
  end

endmodule

`default_nettype wire

// File: beat_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module beat_fifo
(
  input  wire                                         aclk,
  input  wire                                         aresetn,
  input  wire                                         push,
  input  ram_writer_axi_pkg::beat_t                   push_beat,
  input  wire                                         pop,
  output ram_writer_axi_pkg::beat_t                   pop_beat,
  output logic [ram_writer_cfg_pkg::count_width-1:0]  count,
  output logic                                        full
);

  ram_writer_axi_pkg::beat_t mem [ram_writer_cfg_pkg::fifo_depth]; // Beat storage

  logic [ram_writer_cfg_pkg::ptr_width-1:0] wr_ptr;
  logic [ram_writer_cfg_pkg::ptr_width-1:0] rd_ptr;
  logic                                     do_push;
  logic                                     do_pop;

  assign full     = (count == ram_writer_cfg_pkg::fifo_depth);
  assign do_push  = push & ~full;
  assign do_pop   = pop & (count != 0);
  assign pop_beat = mem[rd_ptr];        // Head falls through, valid while count is not zero

  always_ff @(posedge aclk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_beat;
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;        // Both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// File: burst_master.sv
`timescale 1ns/1ps
`default_nettype none

module burst_master
(
  input  wire                                         aclk,
  input  wire                                         aresetn,
  input  wire  [ram_writer_cfg_pkg::addr_width-1:0]   cfg_base,
  input  wire  [ram_writer_cfg_pkg::count_width-1:0]  count,
  input  ram_writer_axi_pkg::beat_t                   pop_beat,
  output logic                                        pop,
  output ram_writer_axi_pkg::aw_t                     m_aw,
  output logic                                        m_awvalid,
  input  wire                                         m_awready,
  output ram_writer_axi_pkg::w_t                      m_w,
  output logic                                        m_wvalid,
  input  wire                                         m_wready
);

  logic                                       aw_valid_q;
  logic                                       w_valid_q;  // Burst data phase in progress
  logic [ram_writer_cfg_pkg::len_width-1:0]   beat_cnt;   // Beat within the burst
  logic [ram_writer_cfg_pkg::addr_width-1:0]  burst_idx;  // Bursts completed since reset
  logic [ram_writer_cfg_pkg::id_width-1:0]    id_q;       // ID of the current burst
  ram_writer_axi_pkg::aw_t                    aw_q;       // Held AW request

  logic                                       aw_hs;
  logic                                       w_hs;
  logic                                       w_last;
  logic                                       w_last_hs;
  logic                                       aw_free;
  logic                                       start_idle;
  logic                                       start_next;
  logic                                       start;
  logic [ram_writer_cfg_pkg::id_width-1:0]    id_sel;
  logic [ram_writer_cfg_pkg::addr_width-1:0]  idx_sel;

  assign aw_hs     = aw_valid_q & m_awready;
  assign w_hs      = w_valid_q & m_wready;
  assign w_last    = (beat_cnt == ram_writer_cfg_pkg::burst_len); // Beat 16 of 16
  assign w_last_hs = w_hs & w_last;
  assign aw_free   = ~aw_valid_q | m_awready;                     // No AW left pending

  // A burst starts only with a whole burst waiting in the FIFO
  assign start_idle = ~w_valid_q & ~aw_valid_q & (count >= ram_writer_cfg_pkg::burst_beats);
  assign start_next = w_last_hs & aw_free & (count > ram_writer_cfg_pkg::burst_beats);
  assign start      = start_idle | start_next;

  // On a back-to-back start the new burst takes the advanced ID and index
  assign id_sel  = w_last_hs ? id_q + 1'b1 : id_q;
  assign idx_sel = w_last_hs ? burst_idx + 1'b1 : burst_idx;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
      beat_cnt   <= '0;
      burst_idx  <= '0;
      id_q       <= '0;
    end
    else
    begin
      if (start)
      begin
        aw_valid_q <= 1'b1;               // AW and W raised together
        w_valid_q  <= 1'b1;
      end
      else
      begin
        if (aw_hs)
          aw_valid_q <= 1'b0;
        if (w_last_hs)
          w_valid_q <= 1'b0;              // Back to idle, AW may still be pending
      end
      if (w_hs)
        beat_cnt <= beat_cnt + 1'b1;      // Wraps to zero after the last beat
      if (w_last_hs)
      begin
        id_q      <= id_q + 1'b1;
        burst_idx <= burst_idx + 1'b1;
      end
    end
  end

  // Base is sampled once per burst
  always_ff @(posedge aclk)
  begin
    if (start)
    begin
      aw_q.id   <= id_sel;
      aw_q.addr <= cfg_base + idx_sel * ram_writer_cfg_pkg::burst_bytes;
      aw_q.len  <= ram_writer_cfg_pkg::burst_len;
    end
  end

  always_comb
  begin
    m_w.id   = id_q;
    m_w.data = pop_beat;                  // FIFO head, stable until popped
    m_w.last = w_last;
  end

  assign m_aw      = aw_q;
  assign m_awvalid = aw_valid_q;
  assign m_wvalid  = w_valid_q;
  assign pop       = w_hs;               // Each accepted beat leaves the FIFO

endmodule

`default_nettype wire

// File: stream_ram_writer.sv
`timescale 1ns/1ps
`default_nettype none

module stream_ram_writer
(
  input  wire                                        aclk,
  input  wire                                        aresetn,
  input  wire  [ram_writer_cfg_pkg::addr_width-1:0]  cfg_base,
  input  wire  [ram_writer_cfg_pkg::word_width-1:0]  s_tdata,
  input  wire                                        s_tvalid,
  output logic                                       s_tready,
  output ram_writer_axi_pkg::aw_t                    m_aw,
  output logic                                       m_awvalid,
  input  wire                                        m_awready,
  output ram_writer_axi_pkg::w_t                     m_w,
  output logic                                       m_wvalid,
  input  wire                                        m_wready
);

  logic                                        push;
  ram_writer_axi_pkg::beat_t                   push_beat;
  logic                                        full;
  logic                                        pop;
  ram_writer_axi_pkg::beat_t                   pop_beat;
  logic [ram_writer_cfg_pkg::count_width-1:0]  count;

  word_packer packer_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .s_tdata   (s_tdata),
    .s_tvalid  (s_tvalid),
    .s_tready  (s_tready),
    .full      (full),
    .push      (push),
    .push_beat (push_beat)
  );

  beat_fifo fifo_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .push      (push),
    .push_beat (push_beat),
    .pop       (pop),
    .pop_beat  (pop_beat),
    .count     (count),
    .full      (full)
  );

  burst_master master_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .cfg_base  (cfg_base),
    .count     (count),
    .pop_beat  (pop_beat),
    .pop       (pop),
    .m_aw      (m_aw),
    .m_awvalid (m_awvalid),
    .m_awready (m_awready),
    .m_w       (m_w),
    .m_wvalid  (m_wvalid),
    .m_wready  (m_wready)
  );

endmodule

`default_nettype wire

// File: stream_ram_writer_props.sv
`timescale 1ns/1ps
`default_nettype none

module stream_ram_writer_props
(
  input  wire                      aclk,
  input  wire                      aresetn,
  input  ram_writer_axi_pkg::aw_t  m_aw,
  input  wire                      m_awvalid,
  input  wire                      m_awready,
  input  ram_writer_axi_pkg::w_t   m_w,
  input  wire                      m_wvalid,
  input  wire                      m_wready
);

  // A raised valid waits for ready
  aw_valid_held: assert property (@(posedge aclk) disable iff (!aresetn)
    (m_awvalid && !m_awready) |=> m_awvalid)
    else $error("m_awvalid dropped before m_awready was seen");

  aw_payload_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    (m_awvalid && !m_awready) |=> $stable(m_aw))
    else $error("m_aw changed while waiting for m_awready");

  w_valid_held: assert property (@(posedge aclk) disable iff (!aresetn)
    (m_wvalid && !m_wready) |=> m_wvalid)
    else $error("m_wvalid dropped before m_wready was seen");

  w_payload_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    (m_wvalid && !m_wready) |=> $stable(m_w))
    else $error("m_w changed while waiting for m_wready");

endmodule

bind burst_master stream_ram_writer_props props_i (
  .aclk      (aclk),
  .aresetn   (aresetn),
  .m_aw      (m_aw),
  .m_awvalid (m_awvalid),
  .m_awready (m_awready),
  .m_w       (m_w),
  .m_wvalid  (m_wvalid),
  .m_wready  (m_wready)
);

`default_nettype wire

// File: tb_write_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_write_checker
(
  input  wire                                        aclk,
  input  wire                                        aresetn,
  input  wire  [ram_writer_cfg_pkg::addr_width-1:0]  cfg_base,
  input  wire  [ram_writer_cfg_pkg::word_width-1:0]  s_tdata,
  input  wire                                        s_tvalid,
  input  wire                                        s_tready,
  input  ram_writer_axi_pkg::aw_t                    m_aw,
  input  wire                                        m_awvalid,
  input  wire                                        m_awready,
  input  ram_writer_axi_pkg::w_t                     m_w,
  input  wire                                        m_wvalid,
  input  wire                                        m_wready,
  output int                                         error_count,
  output int                                         check_count,
  output int                                         beats_seen,
  output int                                         bursts_seen
);

  localparam int words_per_burst = 2 * ram_writer_cfg_pkg::burst_beats;
  localparam int full_words      = 2 * ram_writer_cfg_pkg::fifo_depth; // FIFO full of beats
  localparam int max_held_words  = full_words + 1;                     // Plus a lone first word

  logic [ram_writer_cfg_pkg::word_width-1:0] word_q [$]; // Accepted and not yet written
  int                                        words_seen; // Stream handshakes since reset
  bit                                        reset_seen; // Reset sampled at the previous edge

  // Burst k starts 16 beats of 8 bytes above burst k-1
  function automatic ram_writer_axi_pkg::aw_t predict_aw(
    input logic [ram_writer_cfg_pkg::addr_width-1:0] base,
    input int                                        k
  );
    ram_writer_axi_pkg::aw_t                   aw;
    logic [ram_writer_cfg_pkg::addr_width-1:0] offset;
    offset  = k * ram_writer_cfg_pkg::burst_beats * ram_writer_cfg_pkg::beat_bytes;
    aw.id   = k[ram_writer_cfg_pkg::id_width-1:0];
    aw.addr = base + offset;
    aw.len  = 4'd15;
    return aw;
  endfunction

  // Later word of a pair goes to the upper half
  function automatic ram_writer_axi_pkg::beat_t predict_beat(
    input logic [ram_writer_cfg_pkg::word_width-1:0] first,
    input logic [ram_writer_cfg_pkg::word_width-1:0] second
  );
    ram_writer_axi_pkg::beat_t beat;
    beat.hi = second;
    beat.lo = first;
    return beat;
  endfunction

  task automatic compare_field(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("[FAIL] %s: expected %h, got %h", name, expected, actual);
    end
  endtask

  task automatic report_problem(input string what);
    error_count++;
    $display("ERROR: %s", what);
  endtask

  always @(posedge aclk)
  begin : compare
    ram_writer_axi_pkg::aw_t                   exp_aw;
    ram_writer_axi_pkg::beat_t                 exp_beat;
    logic [ram_writer_cfg_pkg::word_width-1:0] first;
    logic [ram_writer_cfg_pkg::word_width-1:0] second;
    int                                        burst_k;
    if (reset_seen)
    begin
      compare_field("m_awvalid", 64'(1'b0), 64'(m_awvalid));
      compare_field("m_wvalid", 64'(1'b0), 64'(m_wvalid));
      compare_field("s_tready", 64'(1'b1), 64'(s_tready));
    end
    if (!aresetn)
    begin
      word_q.delete();                   // Partial data is dropped by the reset
      words_seen  = 0;
      beats_seen  = 0;
      bursts_seen = 0;
    end
    else
    begin
      if (!s_tready && word_q.size() < full_words)
        report_problem($sformatf("s_tready low with only %0d words held", word_q.size()));
      if (word_q.size() > max_held_words)
        report_problem($sformatf("DUT holds %0d words, more than fit", word_q.size()));
      if (m_awvalid && m_awready)
      begin
        exp_aw = predict_aw(cfg_base, bursts_seen);
        compare_field("m_aw.id", 64'(exp_aw.id), 64'(m_aw.id));
        compare_field("m_aw.addr", 64'(exp_aw.addr), 64'(m_aw.addr));
        compare_field("m_aw.len", 64'(exp_aw.len), 64'(m_aw.len));
        if (words_seen < words_per_burst * (bursts_seen + 1))
          report_problem($sformatf("burst %0d was issued before its words arrived", bursts_seen));
        bursts_seen++;
      end
      if (m_wvalid && m_wready)
      begin
        burst_k = beats_seen / ram_writer_cfg_pkg::burst_beats;
        if (word_q.size() < 2)
          report_problem("W beat accepted without two stream words behind it");
        else
        begin
          first    = word_q.pop_front();
          second   = word_q.pop_front();
          exp_beat = predict_beat(first, second);
          compare_field("m_w.data", 64'(exp_beat), 64'(m_w.data));
        end
        compare_field("m_w.last",
                      64'((beats_seen % ram_writer_cfg_pkg::burst_beats) == 15),
                      64'(m_w.last));
        compare_field("m_w.id", 64'(burst_k[ram_writer_cfg_pkg::id_width-1:0]), 64'(m_w.id));
        beats_seen++;
      end
      if (s_tvalid && s_tready)
      begin
        word_q.push_back(s_tdata);
        words_seen++;
      end
    end
    reset_seen = !aresetn;
  end

endmodule

`default_nettype wire

// File: tb_stream_ram_writer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_stream_ram_writer;

  localparam int max_cycles = 20000;                // Generous bound on the whole run
  localparam logic [31:0] base_a = 32'h8000_0000;
  localparam logic [31:0] base_b = 32'h0004_1f80;

  logic                                      aclk = 1'b0;
  logic                                      aresetn;
  logic [ram_writer_cfg_pkg::addr_width-1:0] cfg_base;
  logic [ram_writer_cfg_pkg::word_width-1:0] s_tdata;
  logic                                      s_tvalid;
  logic                                      s_tready;
  ram_writer_axi_pkg::aw_t                   m_aw;
  logic                                      m_awvalid;
  logic                                      m_awready;
  ram_writer_axi_pkg::w_t                    m_w;
  logic                                      m_wvalid;
  logic                                      m_wready;
  logic                                      hold_wready; // Memory model stalls W
  logic                                      stream_gaps; // Random idle cycles on the stream
  int                                        cycle_count;
  int                                        scenario_errors;
  int                                        seed;
  int                                        error_count;
  int                                        check_count;
  int                                        beats_seen;
  int                                        bursts_seen;

  always #20 aclk = ~aclk;

  always @(posedge aclk)
    cycle_count <= cycle_count + 1;

  // Memory side ready model
  always @(negedge aclk)
  begin
    m_awready <= ($urandom % 4) != 0;
    m_wready  <= hold_wready ? 1'b0 : (($urandom % 4) != 0);
  end

  stream_ram_writer dut_i (
    .aclk(aclk), .aresetn(aresetn), .cfg_base(cfg_base),
    .s_tdata(s_tdata), .s_tvalid(s_tvalid), .s_tready(s_tready),
    .m_aw(m_aw), .m_awvalid(m_awvalid), .m_awready(m_awready),
    .m_w(m_w), .m_wvalid(m_wvalid), .m_wready(m_wready)
  );

  tb_write_checker chk_i (
    .aclk(aclk), .aresetn(aresetn), .cfg_base(cfg_base),
    .s_tdata(s_tdata), .s_tvalid(s_tvalid), .s_tready(s_tready),
    .m_aw(m_aw), .m_awvalid(m_awvalid), .m_awready(m_awready),
    .m_w(m_w), .m_wvalid(m_wvalid), .m_wready(m_wready),
    .error_count(error_count), .check_count(check_count),
    .beats_seen(beats_seen), .bursts_seen(bursts_seen)
  );

  task automatic flag_scenario_error(input string what);
    scenario_errors++;
    $display("ERROR: %s", what);
  endtask

  task automatic apply_reset(input logic [31:0] base);
    @(negedge aclk);
    aresetn  = 1'b0;
    cfg_base = base;                    // Base only moves while in reset
    repeat (10) @(negedge aclk);
    aresetn = 1'b1;
  endtask

  task automatic send_words(input int n);
    bit ready_seen;
    for (int i = 0; i < n; i++)
    begin
      if (stream_gaps && ($urandom % 3) == 0)
      begin
        s_tvalid = 1'b0;
        repeat (($urandom % 3) + 1) @(negedge aclk);
      end
      s_tvalid   = 1'b1;
      s_tdata    = $urandom;
      ready_seen = 1'b0;
      while (!ready_seen)
      begin
        ready_seen = s_tready;            // Stable until the next rising edge
        @(negedge aclk);
      end
    end
    s_tvalid = 1'b0;
  endtask

  task automatic wait_written(input int beats);
    while (beats_seen < beats || bursts_seen * 16 < beats)
      @(negedge aclk);
  endtask

  task automatic set_wready_hold(input logic hold);
    @(posedge aclk);
    hold_wready = hold;
    @(negedge aclk);
  endtask

  task automatic watch_backpressure();
    int waited;
    waited = 0;
    while (s_tready && waited < 400)
    begin
      @(negedge aclk);
      waited++;
    end
    if (s_tready)
      flag_scenario_error("s_tready never dropped while m_wready was held low");
    repeat (30)
    begin
      @(negedge aclk);
      if (s_tready)
        flag_scenario_error("s_tready rose while the FIFO could not drain");
    end
    set_wready_hold(1'b0);
  endtask

  task automatic close_run(input bit timed_out);
    $display("Checks: %0d, checker errors: %0d, scenario errors: %0d",
             check_count, error_count, scenario_errors);
    if (timed_out || error_count != 0 || scenario_errors != 0)
      $display("Some tests failed");
    else
      $display("All tests passed");
    $finish;
  endtask

  initial
  begin
    wait (cycle_count >= max_cycles);
    $display("Timeout: the run did not finish within %0d cycles", max_cycles);
    close_run(1'b1);
  end

  initial
  begin
    seed = 93127;
    void'($urandom(seed));
    aresetn     = 1'b0;
    cfg_base    = base_a;
    s_tdata     = '0;
    s_tvalid    = 1'b0;
    m_awready   = 1'b0;
    m_wready    = 1'b0;
    hold_wready = 1'b0;
    stream_gaps = 1'b1;
    apply_reset(base_a);
    send_words(320);                    // Ten bursts with random gaps and readies
    wait_written(160);
    stream_gaps = 1'b0;
    set_wready_hold(1'b1);
    fork
      send_words(160);
      watch_backpressure();
    join
    wait_written(240);
    apply_reset(base_b);                // Second base after a fresh reset
    stream_gaps = 1'b1;
    send_words(256);
    wait_written(128);
    apply_reset(base_a);
    send_words(20);                     // Ten beats are not enough for a burst
    repeat (200)
    begin
      @(negedge aclk);
      if (m_awvalid)
        flag_scenario_error("m_awvalid raised with fewer than 16 beats buffered");
    end
    send_words(12);
    wait_written(16);
    repeat (50) @(negedge aclk);
    if (bursts_seen != 1 || beats_seen != 16 || m_awvalid)
      flag_scenario_error("partial data did not produce exactly one burst");
    close_run(1'b0);
  end

endmodule

`default_nettype wire

// File: all.f
ram_writer_cfg_pkg.sv
ram_writer_axi_pkg.sv
word_packer.sv
beat_fifo.sv
burst_master.sv
stream_ram_writer.sv
stream_ram_writer_props.sv
tb_write_checker.sv
tb_stream_ram_writer.sv

// File: Bender.yml
package:
  name: stream_ram_writer

sources:
  - ram_writer_cfg_pkg.sv
  - ram_writer_axi_pkg.sv
  - word_packer.sv
  - beat_fifo.sv
  - burst_master.sv
  - stream_ram_writer.sv
  - target: test
    files:
      - stream_ram_writer_props.sv
      - tb_write_checker.sv
      - tb_stream_ram_writer.sv
